// File: tb.f
rtl/soc_bus_pkg.sv
rtl/soc_misc_pkg.sv
rtl/bus_decoder.sv
rtl/misc_regs.sv
rtl/fpga_reload_seq.sv
rtl/soc_top.sv
bench/soc_chk.sv
bench/tb_soc.sv

// File: Makefile
# Verilator build for the system-control slice
# the simulation exits non-zero when the testbench fails

VERILATOR ?= verilator
TOP       ?= tb_soc
RTL_TOP   ?= soc_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_soc.sv
// ------------------------------
// testbench for the system-control slice
// region 2 registers, bus errors, interrupts and flash reload
// ends with $fatal at the first mismatch or timeout
// ------------------------------

`timescale 1ns/1ps

module tb_soc
	import soc_bus_pkg::*;
	import soc_misc_pkg::*;
();

	localparam logic [31:0] SEED          = 32'h9f5d_87f9;
	localparam int          HALF_PERIOD   = 20;
	localparam int          RESET_CYCLES  = 5;
	localparam int          READY_TIMEOUT = 16;

	logic               clk48m = 1'b0;
	logic               rst;
	logic               bus_valid;
	bus_req_t           bus_req;
	bus_rsp_t           bus_rsp;
	logic [7:0]         btn;
	logic [13:0]        led;
	logic [GENIO_W-1:0] genio_in;
	logic [GENIO_W-1:0] genio_out;
	logic [GENIO_W-1:0] genio_oe;
	gpext_word_t        gpext_in;
	gpext_out_t         gpext_out;
	gpext_out_t         gpext_oe;
	logic               trace_en;
	logic               fsel_d;
	logic               fsel_c;
	logic               programn;
	logic               irq_usb;
	logic               irq_copper;
	logic               irq_audio;
	logic [IRQ_W-1:0]   irq;

	// register model state
	logic [13:0]        m_led;
	logic               m_trace;
	logic               m_fsel_d;
	logic [GENIO_W-1:0] m_gout;
	logic [GENIO_W-1:0] m_goe;
	gpext_out_t         m_xout;
	gpext_out_t         m_xoe;
	logic               cmp_en;
	string              test_name;

	always #HALF_PERIOD clk48m = ~clk48m;

	soc_top soc_top_i (
		.clk48m       (clk48m),
		.rst          (rst),
		.bus_valid_i  (bus_valid),
		.bus_req_i    (bus_req),
		.bus_rsp_o    (bus_rsp),
		.btn_i        (btn),
		.led_o        (led),
		.genio_in_i   (genio_in),
		.genio_out_o  (genio_out),
		.genio_oe_o   (genio_oe),
		.gpext_in_i   (gpext_in),
		.gpext_out_o  (gpext_out),
		.gpext_oe_o   (gpext_oe),
		.trace_en_o   (trace_en),
		.fsel_d_o     (fsel_d),
		.fsel_c_o     (fsel_c),
		.programn_o   (programn),
		.irq_usb_i    (irq_usb),
		.irq_copper_i (irq_copper),
		.irq_audio_i  (irq_audio),
		.irq_o        (irq)
	);

	task automatic check(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		if (act_val !== exp_val) begin
			$display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
			$display("TEST RESULT: FAIL");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	// ------------------------------
	// reference model
	// ------------------------------

	// pin fields at bits 30, 23:16, 13:8 and 5:0 of the bus word
	function automatic gpext_out_t ext_fields(input logic [31:0] w);
		gpext_out_t g;
		g.irda_sd = w[30];
		g.pmod    = w[23:16];
		g.sao2    = w[13:8];
		g.sao1    = w[5:0];
		return g;
	endfunction

	function automatic logic [31:0] ext_word(input logic top, input gpext_out_t g);
		return {top, g.irda_sd, 6'h0, g.pmod, 2'h0, g.sao2, 2'h0, g.sao1};
	endfunction

	function automatic logic [31:0] expected_read(input misc_idx_t idx);
		case (idx)
			MISC_LED:       return {18'h0, m_led};
			MISC_BTN:       return {24'h0, ~btn};
			MISC_SOC_VER:   return SOC_VERSION;
			MISC_FLASH_SEL: return {31'h0, m_fsel_d};
			MISC_GENIO_IN:  return {2'h0, genio_in};
			MISC_GENIO_OUT: return {2'h0, m_gout};
			MISC_GENIO_OE:  return {2'h0, m_goe};
			// input irda bit is not reported
			MISC_GPEXT_IN:  return {gpext_in[31], 7'h0, gpext_in[23:16], 2'h0,
					gpext_in[13:8], 2'h0, gpext_in[5:0]};
			MISC_GPEXT_OUT: return ext_word(1'b0, m_xout);
			MISC_GPEXT_OE:  return ext_word(1'b0, m_xoe);
			default:        return 32'h0;
		endcase
	endfunction

	task automatic model_write(input misc_idx_t idx, input logic [31:0] w);
		case (idx)
			MISC_LED:       m_led = w[13:0];
			MISC_SOC_VER:   m_trace = w[0];
			MISC_FLASH_SEL: m_fsel_d = w[0];
			MISC_GENIO_OUT: m_gout = w[GENIO_W-1:0];
			MISC_GENIO_OE:  m_goe = w[GENIO_W-1:0];
			MISC_GENIO_W2S: m_gout = m_gout | w[GENIO_W-1:0];
			MISC_GENIO_W2C: m_gout = m_gout & ~w[GENIO_W-1:0];
			MISC_GPEXT_OUT: m_xout = ext_fields(w);
			MISC_GPEXT_OE: begin
				m_xoe         = ext_fields(w);
				m_xoe.irda_sd = 1'b0;
			end
			MISC_GPEXT_W2S: m_xout = m_xout | ext_fields(w);
			MISC_GPEXT_W2C: m_xout = m_xout & ~ext_fields(w);
			default: ;
		endcase
	endtask

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	function automatic logic [31:0] misc_addr(input misc_idx_t idx);
		return {REGION_MISC, 21'($urandom), idx, 2'b00};
	endfunction

	task automatic drive_pins();
		@(posedge clk48m);
		btn        <= 8'($urandom);
		genio_in   <= 30'($urandom);
		gpext_in   <= $urandom;
		irq_usb    <= 1'($urandom);
		irq_copper <= 1'($urandom);
		irq_audio  <= 1'($urandom);
	endtask

	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		int waited;
		@(posedge clk48m);
		bus_valid <= 1'b1;
		bus_req   <= '{addr: addr, wdata: wdata, wstrb: wstrb};
		waited = 0;
		do begin
			@(negedge clk48m);
			waited++;
		end while (!bus_rsp.ready && waited < READY_TIMEOUT);
		if (!bus_rsp.ready) begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "bus ready not seen within %0d cycles of valid", READY_TIMEOUT);
		end
		if (addr[31:28] != REGION_MISC) begin
			check({test_name, " error rdata"}, BUS_ERROR_WORD, bus_rsp.rdata);
		end else if (wstrb == 4'h0) begin
			check({test_name, " rdata"}, expected_read(addr[6:2]), bus_rsp.rdata);
		end
		// accept edge
		@(posedge clk48m);
		bus_valid <= 1'b0;
		if (addr[31:28] == REGION_MISC && wstrb[0]) begin
			model_write(addr[6:2], wdata);
		end
	endtask

	task automatic exercise_regs(input misc_idx_t wr_base, input int wr_span,
			input misc_idx_t rd_base, input int rd_span, input int rounds);
		misc_idx_t  idx;
		logic [3:0] strb;
		for (int r = 0; r < rounds; r++) begin
			drive_pins();
			idx  = wr_base + 5'($urandom_range(wr_span - 1, 0));
			strb = 4'($urandom_range(15, 1));
			bus_access(misc_addr(idx), $urandom, strb);
			idx = rd_base + 5'($urandom_range(rd_span - 1, 0));
			bus_access(misc_addr(idx), 32'h0, 4'h0);
		end
	endtask

	// counts cycles from the accept edge of a flash-select write
	task automatic watch_reload(input logic keyed);
		logic exp_c;
		logic exp_pn;
		for (int k = 1; k <= 12; k++) begin
			@(negedge clk48m);
			exp_c  = (k >= 3) && (k <= 5);
			exp_pn = !(keyed && (k >= 8));
			check({test_name, " fsel_c"}, {31'h0, exp_c}, {31'h0, fsel_c});
			check({test_name, " programn"}, {31'h0, exp_pn}, {31'h0, programn});
		end
	endtask

	// ------------------------------
	// output comparison
	// ------------------------------

	always @(negedge clk48m) begin : compare_outputs
		logic [IRQ_W-1:0] exp_irq;
		if (cmp_en) begin
			exp_irq                = '0;
			exp_irq[IRQ_BUS_ERROR] = bus_valid && (bus_req.addr[31:28] != REGION_MISC);
			exp_irq[IRQ_USB]       = irq_usb;
			exp_irq[IRQ_COPPER]    = irq_copper;
			exp_irq[IRQ_AUDIO]     = irq_audio;
			check({test_name, " led"}, {18'h0, m_led}, {18'h0, led});
			check({test_name, " trace_en"}, {31'h0, m_trace}, {31'h0, trace_en});
			check({test_name, " genio_out"}, {2'h0, m_gout}, {2'h0, genio_out});
			check({test_name, " genio_oe"}, {2'h0, m_goe}, {2'h0, genio_oe});
			check({test_name, " gpext_out"}, {11'h0, m_xout}, {11'h0, gpext_out});
			check({test_name, " gpext_oe"}, {11'h0, m_xoe}, {11'h0, gpext_oe});
			check({test_name, " fsel_d"}, {31'h0, m_fsel_d}, {31'h0, fsel_d});
			check({test_name, " ready"}, {31'h0, bus_valid}, {31'h0, bus_rsp.ready});
			check({test_name, " irq"}, exp_irq, irq);
		end
	end

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin : run_tests
		logic [3:0] region;
		void'($urandom(SEED));
		cmp_en         = 1'b0;
		test_name      = "reset";
		m_led          = '0;
		m_trace        = 1'b0;
		m_fsel_d       = 1'b0;
		m_gout         = '0;
		m_goe          = '0;
		m_xout         = '0;
		m_xout.irda_sd = 1'b1;
		m_xoe          = '0;
		rst        <= 1'b1;
		bus_valid  <= 1'b0;
		bus_req    <= '0;
		btn        <= '0;
		genio_in   <= '0;
		gpext_in   <= '0;
		irq_usb    <= 1'b0;
		irq_copper <= 1'b0;
		irq_audio  <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk48m);
		rst    <= 1'b0;
		cmp_en = 1'b1;

		@(negedge clk48m);
		check("reset programn", 32'd1, {31'h0, programn});
		check("reset fsel_c", 32'd0, {31'h0, fsel_c});
		check("reset irda_sd", 32'd1, {31'h0, gpext_out.irda_sd});
		for (int i = 0; i < 32; i++) begin
			bus_access(misc_addr(5'(i)), 32'h0, 4'h0);
		end

		test_name = "genio";
		exercise_regs(MISC_GENIO_OUT, 4, MISC_GENIO_IN, 3, 30);

		test_name = "gpext";
		exercise_regs(MISC_GPEXT_OUT, 4, MISC_GPEXT_IN, 3, 30);
		test_name = "led_btn";
		exercise_regs(MISC_LED, 3, MISC_LED, 3, 12);
		// led latch and trace enable each take a known non-zero value once
		bus_access(misc_addr(MISC_LED), 32'h0000_2a5c, 4'h1);
		bus_access(misc_addr(MISC_LED), 32'h0, 4'h0);
		bus_access(misc_addr(MISC_SOC_VER), 32'h1, 4'h1);
		bus_access(misc_addr(MISC_SOC_VER), 32'h0, 4'h1);

		test_name = "bus_error";
		for (int i = 0; i < 10; i++) begin
			drive_pins();
			region = 4'($urandom_range(14, 0));
			if (region >= REGION_MISC) begin
				region = region + 4'd1;
			end
			bus_access({region, 28'($urandom)}, $urandom, (i % 2 == 1) ? 4'hf : 4'h0);
		end

		test_name = "fsel_nokey";
		bus_access(misc_addr(MISC_FLASH_SEL), {RELOAD_KEY ^ 24'h00_0100, 8'h01}, 4'hf);
		watch_reload(1'b0);
		bus_access(misc_addr(MISC_FLASH_SEL), 32'h0, 4'h0);

		test_name = "fsel_key";
		bus_access(misc_addr(MISC_FLASH_SEL), {RELOAD_KEY, 8'h00}, 4'hf);
		watch_reload(1'b1);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: bench/soc_chk.sv
// ------------------------------
// bound checks on soc_top
// handshake and reload output rules
// ------------------------------

`timescale 1ns/1ps

module soc_chk (
	input logic clk48m,
	input logic rst,
	input logic bus_valid_i,
	input logic ready_i,
	input logic fsel_c_i,
	input logic programn_i
);

	// ready only answers a valid request
	a_ready_needs_valid: assert property (@(posedge clk48m) disable iff (rst)
		ready_i |-> bus_valid_i)
		else $error("bus ready high without valid");

	// reload is one-way until reset
	a_programn_stays_low: assert property (@(posedge clk48m) disable iff (rst)
		!programn_i |=> !programn_i)
		else $error("programn rose again after going low");

	// select clock pulse is three cycles at most
	a_fsel_c_max_three: assert property (@(posedge clk48m) disable iff (rst)
		!(fsel_c_i && $past(fsel_c_i, 1) && $past(fsel_c_i, 2) && $past(fsel_c_i, 3)))
		else $error("fsel_c high for more than three cycles");

endmodule

bind soc_top soc_chk soc_chk_i (
	.clk48m      (clk48m),
	.rst         (rst),
	.bus_valid_i (bus_valid_i),
	.ready_i     (bus_rsp_o.ready),
	.fsel_c_i    (fsel_c_o),
	.programn_i  (programn_o)
);

// File: rtl/soc_top.sv
// ------------------------------
// system-control slice of the badge SoC
// one bus master, region 2 only, other regions error
// ------------------------------

`timescale 1ns/1ps

module soc_top
	import soc_bus_pkg::*;
	import soc_misc_pkg::*;
(
	input  logic               clk48m,
	input  logic               rst,
	input  logic               bus_valid_i,
	input  bus_req_t           bus_req_i,
	output bus_rsp_t           bus_rsp_o,
	input  logic [7:0]         btn_i,
	output logic [13:0]        led_o,
	input  logic [GENIO_W-1:0] genio_in_i,
	output logic [GENIO_W-1:0] genio_out_o,
	output logic [GENIO_W-1:0] genio_oe_o,
	input  gpext_word_t        gpext_in_i,
	output gpext_out_t         gpext_out_o,
	output gpext_out_t         gpext_oe_o,
	output logic               trace_en_o,
	output logic               fsel_d_o,
	output logic               fsel_c_o,
	output logic               programn_o,
	input  logic               irq_usb_i,
	input  logic               irq_copper_i,
	input  logic               irq_audio_i,
	output logic [IRQ_W-1:0]   irq_o
);

	logic        misc_sel;
	logic [31:0] misc_rdata;
	logic        bus_err;
	logic        fsel_wr;
	misc_wdata_u fsel_word;

	bus_decoder bus_decoder_i (
		.bus_valid_i  (bus_valid_i),
		.bus_req_i    (bus_req_i),
		.misc_rdata_i (misc_rdata),
		.misc_sel_o   (misc_sel),
		.bus_rsp_o    (bus_rsp_o),
		.bus_err_o    (bus_err)
	);

	misc_regs misc_regs_i (
		.clk48m      (clk48m),
		.rst         (rst),
		.misc_sel_i  (misc_sel),
		.bus_req_i   (bus_req_i),
		.rdata_o     (misc_rdata),
		.btn_i       (btn_i),
		.genio_in_i  (genio_in_i),
		.genio_out_o (genio_out_o),
		.genio_oe_o  (genio_oe_o),
		.gpext_in_i  (gpext_in_i),
		.gpext_out_o (gpext_out_o),
		.gpext_oe_o  (gpext_oe_o),
		.led_o       (led_o),
		.trace_en_o  (trace_en_o),
		.fsel_d_i    (fsel_d_o),
		.fsel_wr_o   (fsel_wr),
		.fsel_word_o (fsel_word)
	);

	fpga_reload_seq fpga_reload_seq_i (
		.clk48m      (clk48m),
		.rst         (rst),
		.fsel_wr_i   (fsel_wr),
		.fsel_word_i (fsel_word),
		.fsel_d_o    (fsel_d_o),
		.fsel_c_o    (fsel_c_o),
		.programn_o  (programn_o)
	);

	// ------------------------------
	// interrupt vector
	// ------------------------------

	// bits 0 to 2 are raised inside the CPU
	always_comb begin
		irq_o                = '0;
		irq_o[IRQ_BUS_ERROR] = bus_err;
		irq_o[IRQ_USB]       = irq_usb_i;
		irq_o[IRQ_COPPER]    = irq_copper_i;
		irq_o[IRQ_AUDIO]     = irq_audio_i;
	end

endmodule

// File: rtl/fpga_reload_seq.sv
// ------------------------------
// boot flash select and reload trigger
// select clock pulses while the delay counter is 5 down to 3
// PROGRAMN stays low until reset once the key was given
// ------------------------------

`timescale 1ns/1ps

module fpga_reload_seq
	import soc_misc_pkg::*;
(
	input  logic        clk48m,
	input  logic        rst,
	input  logic        fsel_wr_i,
	input  misc_wdata_u fsel_word_i,
	output logic        fsel_d_o,
	output logic        fsel_c_o,
	output logic        programn_o
);

	logic [2:0] dly_q;
	logic       key_ok_q;
	logic       reload_q;

	// data is set up well before the flash mux flop is clocked
	always_ff @(posedge clk48m) begin
		if (rst) begin
			fsel_d_o <= 1'b0;
			dly_q    <= 3'd0;
			key_ok_q <= 1'b0;
			reload_q <= 1'b0;
		end else if (fsel_wr_i) begin
			fsel_d_o <= fsel_word_i.fsel.sel;
			key_ok_q <= (fsel_word_i.fsel.key == RELOAD_KEY);
			dly_q    <= 3'd7;
		end else if (dly_q != 3'd0) begin
			dly_q <= dly_q - 3'd1;
			// reload once the select clock is done
			if (dly_q == 3'd1 && key_ok_q) begin
				reload_q <= 1'b1;
			end
		end
	end

	assign fsel_c_o   = (dly_q == 3'd5) || (dly_q == 3'd4) || (dly_q == 3'd3);
	assign programn_o = ~reload_q;

endmodule

// File: rtl/misc_regs.sv
// ------------------------------
// misc registers: leds, buttons, general I/O, extension port
// writes need wstrb bit 0, the whole word is taken
// W2S and W2C act on the output registers only
// ------------------------------

`timescale 1ns/1ps

module misc_regs
	import soc_bus_pkg::*;
	import soc_misc_pkg::*;
(
	input  logic               clk48m,
	input  logic               rst,
	input  logic               misc_sel_i,
	input  bus_req_t           bus_req_i,
	output logic [31:0]        rdata_o,
	input  logic [7:0]         btn_i,
	input  logic [GENIO_W-1:0] genio_in_i,
	output logic [GENIO_W-1:0] genio_out_o,
	output logic [GENIO_W-1:0] genio_oe_o,
	input  gpext_word_t        gpext_in_i,
	output gpext_out_t         gpext_out_o,
	output gpext_out_t         gpext_oe_o,
	output logic [13:0]        led_o,
	output logic               trace_en_o,
	input  logic               fsel_d_i,
	output logic               fsel_wr_o,
	output misc_wdata_u        fsel_word_o
);

	misc_idx_t          idx;
	logic               wr_en;
	misc_wdata_u        wword;
	gpext_out_t         w_ext;
	logic [GENIO_W-1:0] w_genio;

	// place pin groups back into the bus word layout
	function automatic gpext_word_t ext_word(input logic top, input gpext_out_t g);
		gpext_word_t w;
		w         = '0;
		w.usb_det = top;
		w.irda_sd = g.irda_sd;
		w.pmod    = g.pmod;
		w.sao2    = g.sao2;
		w.sao1    = g.sao1;
		return w;
	endfunction

	assign idx     = bus_req_i.addr[6:2];
	assign wr_en   = misc_sel_i && bus_req_i.wstrb[0];
	assign wword   = bus_req_i.wdata;
	assign w_genio = bus_req_i.wdata[GENIO_W-1:0];

	// extension fields pulled out of the write word
	assign w_ext = '{
		irda_sd: wword.gpext.irda_sd,
		pmod:    wword.gpext.pmod,
		sao2:    wword.gpext.sao2,
		sao1:    wword.gpext.sao1
	};

	// flash select goes to the sequencer as a strobe
	assign fsel_wr_o   = wr_en && (idx == MISC_FLASH_SEL);
	assign fsel_word_o = wword;

	// ------------------------------
	// register writes
	// ------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o       <= '0;
			trace_en_o  <= 1'b0;
			genio_out_o <= '0;
			genio_oe_o  <= '0;
			gpext_out_o <= '{irda_sd: 1'b1, default: '0};
			gpext_oe_o  <= '0;
		end else if (wr_en) begin
			case (idx)
				MISC_LED:       led_o <= bus_req_i.wdata[13:0];
				// trace enable lives behind the version index
				MISC_SOC_VER:   trace_en_o <= bus_req_i.wdata[0];
				MISC_GENIO_OUT: genio_out_o <= w_genio;
				MISC_GENIO_OE:  genio_oe_o <= w_genio;
				MISC_GENIO_W2S: genio_out_o <= genio_out_o | w_genio;
				MISC_GENIO_W2C: genio_out_o <= genio_out_o & ~w_genio;
				MISC_GPEXT_OUT: gpext_out_o <= w_ext;
				// irda shutdown has no enable
				MISC_GPEXT_OE:  gpext_oe_o <= '{irda_sd: 1'b0, pmod: w_ext.pmod,
						sao2: w_ext.sao2, sao1: w_ext.sao1};
				MISC_GPEXT_W2S: gpext_out_o <= gpext_out_o | w_ext;
				MISC_GPEXT_W2C: gpext_out_o <= gpext_out_o & ~w_ext;
				default: ;
			endcase
		end
	end

	// ------------------------------
	// readback
	// ------------------------------

	always_comb begin
		case (idx)
			MISC_LED:       rdata_o = {18'h0, led_o};
			// buttons are active low on the board
			MISC_BTN:       rdata_o = {24'h0, ~btn_i};
			MISC_SOC_VER:   rdata_o = SOC_VERSION;
			MISC_FLASH_SEL: rdata_o = {31'h0, fsel_d_i};
			MISC_GENIO_IN:  rdata_o = {2'h0, genio_in_i};
			MISC_GENIO_OUT: rdata_o = {2'h0, genio_out_o};
			MISC_GENIO_OE:  rdata_o = {2'h0, genio_oe_o};
			MISC_GPEXT_IN:  rdata_o = ext_word(gpext_in_i.usb_det, '{irda_sd: 1'b0,
					pmod: gpext_in_i.pmod, sao2: gpext_in_i.sao2, sao1: gpext_in_i.sao1});
			MISC_GPEXT_OUT: rdata_o = ext_word(1'b0, gpext_out_o);
			MISC_GPEXT_OE:  rdata_o = ext_word(1'b0, gpext_oe_o);
			default:        rdata_o = 32'h0;
		endcase
	end

endmodule

// File: rtl/bus_decoder.sv
// ------------------------------
// region decode for the single bus master
// purely combinational, ready equals valid
// only region 2 is populated
// ------------------------------

`timescale 1ns/1ps

module bus_decoder
	import soc_bus_pkg::*;
(
	input  logic        bus_valid_i,
	input  bus_req_t    bus_req_i,
	input  logic [31:0] misc_rdata_i,
	output logic        misc_sel_o,
	output bus_rsp_t    bus_rsp_o,
	output logic        bus_err_o
);

	logic [3:0] region;
	logic       misc_hit;

	assign region   = bus_req_i.addr[31:28];
	assign misc_hit = (region == REGION_MISC);

	// ------------------------------
	// selects
	// ------------------------------

	assign misc_sel_o = bus_valid_i && misc_hit;

	// anything outside the map errors in the same cycle
	assign bus_err_o = bus_valid_i && !misc_hit;

	// ------------------------------
	// response
	// ------------------------------

	always_comb begin
		bus_rsp_o.ready = misc_sel_o || bus_err_o;
		if (misc_hit) begin
			bus_rsp_o.rdata = misc_rdata_i;
		end else begin
			bus_rsp_o.rdata = BUS_ERROR_WORD;
		end
	end

endmodule

// File: rtl/soc_misc_pkg.sv
// ------------------------------
// misc register block definitions
// register index is word address bits 6:2
// extension and flash-select words share one bus word layout slot
// ------------------------------

package soc_misc_pkg;

	typedef logic [4:0] misc_idx_t;

	// ------------------------------
	// register indices
	// ------------------------------

	localparam misc_idx_t MISC_LED       = 5'd0;
	localparam misc_idx_t MISC_BTN       = 5'd1;
	localparam misc_idx_t MISC_SOC_VER   = 5'd2;
	localparam misc_idx_t MISC_FLASH_SEL = 5'd13;
	localparam misc_idx_t MISC_GENIO_IN  = 5'd17;
	localparam misc_idx_t MISC_GENIO_OUT = 5'd18;
	localparam misc_idx_t MISC_GENIO_OE  = 5'd19;
	localparam misc_idx_t MISC_GENIO_W2S = 5'd20;
	localparam misc_idx_t MISC_GENIO_W2C = 5'd21;
	localparam misc_idx_t MISC_GPEXT_IN  = 5'd22;
	localparam misc_idx_t MISC_GPEXT_OUT = 5'd23;
	localparam misc_idx_t MISC_GPEXT_OE  = 5'd24;
	localparam misc_idx_t MISC_GPEXT_W2S = 5'd25;
	localparam misc_idx_t MISC_GPEXT_W2C = 5'd26;

	localparam logic [31:0] SOC_VERSION = 32'h0000_0000;
	localparam int unsigned GENIO_W     = 30;

	// writing this key with the select word triggers an FPGA reload
	localparam logic [23:0] RELOAD_KEY = 24'hd0f1a5;

	// ------------------------------
	// word layouts
	// ------------------------------

	// extension port word, as seen on the bus
	typedef struct packed {
		logic       usb_det;
		logic       irda_sd;
		logic [5:0] rsvd_hi;
		logic [7:0] pmod;
		logic [1:0] rsvd_mid;
		logic [5:0] sao2;
		logic [1:0] rsvd_lo;
		logic [5:0] sao1;
	} gpext_word_t;

	// flash-select word
	typedef struct packed {
		logic [23:0] key;
		logic [6:0]  rsvd;
		logic        sel;
	} fsel_word_t;

	// one write word, decoded by register index
	typedef union packed {
		gpext_word_t gpext;
		fsel_word_t  fsel;
	} misc_wdata_u;

	// extension pins, used for both the output and enable groups
	typedef struct packed {
		logic       irda_sd;
		logic [7:0] pmod;
		logic [5:0] sao2;
		logic [5:0] sao1;
	} gpext_out_t;

endpackage

// File: rtl/soc_bus_pkg.sv
// ------------------------------
// system bus types and region map
// one master, every access completes in its accept cycle
// a zero write strobe marks a read
// ------------------------------

package soc_bus_pkg;

	// ------------------------------
	// bus request and response
	// ------------------------------

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
	} bus_rsp_t;

	// ------------------------------
	// address map
	// ------------------------------

	// region is taken from address bits 31:28
	localparam logic [3:0] REGION_MISC = 4'h2;

	// returned for any access outside the decoded regions
	localparam logic [31:0] BUS_ERROR_WORD = 32'hdead_beef;

	// ------------------------------
	// interrupt vector layout
	// ------------------------------

	localparam int unsigned IRQ_W         = 32;
	localparam int unsigned IRQ_BUS_ERROR = 3;
	localparam int unsigned IRQ_USB       = 4;
	localparam int unsigned IRQ_COPPER    = 5;
	localparam int unsigned IRQ_AUDIO     = 6;

endpackage
